// File: access_port_pkg.sv
package access_port_pkg;

  // ----------------------------------------------------------
  // Access port read sizes
  // ----------------------------------------------------------

  // Codes 4 to 7 on the 3-bit size input have no name and are ignored
  typedef enum logic [1:0] {
    WS_8BIT  = 2'd0,
    WS_16BIT = 2'd1,
    WS_32BIT = 2'd2,
    WS_64BIT = 2'd3
  } word_size_e;

  // ----------------------------------------------------------
  // Controller states
  // ----------------------------------------------------------

  typedef enum logic {
    LD_IDLE    = 1'b0,
    LD_LOADING = 1'b1
  } loader_state_e;

  // WAIT states present the address and TAKE states see the RAM word
  typedef enum logic [2:0] {
    RD_IDLE        = 3'd0,
    RD_SINGLE_WAIT = 3'd1,
    RD_SINGLE_TAKE = 3'd2,
    RD_FIRST_WAIT  = 3'd3,
    RD_FIRST_TAKE  = 3'd4,
    RD_SECOND_TAKE = 3'd5
  } reader_state_e;

endpackage

// File: access_port_reader.sv
`timescale 1ns/1ps

module access_port_reader #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                                               i_clk,
  input  logic                                               i_areset,
  input  logic                                               i_rd_en,
  input  logic [ADDR_WIDTH+rx_buffer_pkg::BYTE_LANE_BITS-1:0] i_addr,
  input  logic [2:0]                                         i_wordsize,
  output logic                                               o_wait,
  output logic                                               o_rd_dv,
  output rx_buffer_pkg::word_t                               o_rd_data,
  rx_ram_if.reader                                           mem
);
  import rx_buffer_pkg::*;
  import access_port_pkg::*;

  // Byte counts run from 1 to 8 so they need one bit above the lane bits
  localparam int CNT_W = BYTE_LANE_BITS + 1;

  typedef logic [CNT_W-1:0] byte_cnt_t;

  // Control state
  reader_state_e state_q;
  logic          wait_q;
  logic          done_q;
  logic          dv_q;

  // Registered request
  logic [BYTE_LANE_BITS-1:0] offset_q;
  word_size_e                size_q;
  logic [ADDR_WIDTH-1:0]     rd_word_q;

  // Result under assembly and the result shown on the port
  word_t asm_q;
  word_t result_q;

  // Request decode
  logic [BYTE_LANE_BITS-1:0] req_offset;
  word_size_e                req_size;
  logic                      req_valid;
  logic                      req_cross;
  logic                      accept;

  // Byte extraction
  byte_cnt_t size_bytes;
  byte_cnt_t tail_bytes;
  word_t     head_part;
  word_t     tail_part;

  function automatic byte_cnt_t size_in_bytes(word_size_e ws);
    return byte_cnt_t'(1) << ws;
  endfunction

  // ----------------------------------------------------------
  // Request decode
  // ----------------------------------------------------------

  assign req_offset = i_addr[BYTE_LANE_BITS-1:0];
  assign req_size   = word_size_e'(i_wordsize[1:0]);
  assign req_valid  = !i_wordsize[2];

  // Crosses into the next word when the last byte lies beyond lane 7
  assign req_cross = ({1'b0, req_offset} + size_in_bytes(req_size)) > BYTES_PER_WORD;

  // New reads are ignored until the current result has been delivered
  assign accept = (state_q == RD_IDLE) && !wait_q && i_rd_en && req_valid;

  // ----------------------------------------------------------
  // Read sequence FSM
  // ----------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= RD_IDLE;
      wait_q  <= 1'b0;
      done_q  <= 1'b0;
      dv_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      dv_q   <= done_q;
      if (done_q) begin
        wait_q <= 1'b0;
      end
      case (state_q)
        RD_IDLE: begin
          if (accept) begin
            wait_q  <= 1'b1;
            state_q <= req_cross ? RD_FIRST_WAIT : RD_SINGLE_WAIT;
          end
        end
        RD_SINGLE_WAIT: begin
          state_q <= RD_SINGLE_TAKE;
        end
        RD_SINGLE_TAKE: begin
          state_q <= RD_IDLE;
          done_q  <= 1'b1;
        end
        RD_FIRST_WAIT: begin
          state_q <= RD_FIRST_TAKE;
        end
        RD_FIRST_TAKE: begin
          state_q <= RD_SECOND_TAKE;
        end
        RD_SECOND_TAKE: begin
          state_q <= RD_IDLE;
          done_q  <= 1'b1;
        end
        default: begin
          state_q <= RD_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Big-endian byte extraction
  // ----------------------------------------------------------

  assign size_bytes = size_in_bytes(size_q);

  // Bytes that come from the second word of a crossing read
  assign tail_bytes = byte_cnt_t'({1'b0, offset_q} + size_bytes - BYTES_PER_WORD);

  // Drop the bytes before the offset, then right-align the requested size.
  // For a crossing read the low bytes stay zero for the second word.
  assign head_part = (mem.rd_data << (8 * offset_q)) >> (8 * (BYTES_PER_WORD - size_bytes));

  // Leading bytes of the second word placed at the bottom
  assign tail_part = mem.rd_data >> (8 * (BYTES_PER_WORD - tail_bytes));

  always_ff @(posedge i_clk) begin
    if (accept) begin
      offset_q  <= req_offset;
      size_q    <= req_size;
      rd_word_q <= i_addr[ADDR_WIDTH+BYTE_LANE_BITS-1:BYTE_LANE_BITS];
    end
    // Second word address goes out while the first word is read
    if (state_q == RD_FIRST_WAIT) begin
      rd_word_q <= rd_word_q + 1'b1;
    end
    if ((state_q == RD_SINGLE_TAKE) || (state_q == RD_FIRST_TAKE)) begin
      asm_q <= head_part;
    end
    if (state_q == RD_SECOND_TAKE) begin
      asm_q <= asm_q | tail_part;
    end
    if (done_q) begin
      result_q <= asm_q;
    end
  end

  assign mem.rd_addr = rd_word_q;
  assign o_wait      = wait_q;
  assign o_rd_dv     = dv_q;
  assign o_rd_data   = result_q;

  // ----------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------

  a_dv_not_waiting: assert property (@(posedge i_clk) disable iff (i_areset)
    o_rd_dv |-> !o_wait);

  a_dv_one_cycle: assert property (@(posedge i_clk) disable iff (i_areset)
    o_rd_dv |=> !o_rd_dv);

  // Result arrives three cycles after wait rises, or four for a crossing read
  a_dv_latency: assert property (@(posedge i_clk) disable iff (i_areset)
    $rose(o_wait) |-> ##[3:4] $rose(o_rd_dv));

endmodule

// File: dispatch_loader.sv
`timescale 1ns/1ps

module dispatch_loader #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                 i_clk,
  input  logic                 i_areset,
  input  logic                 i_parser_busy,
  input  logic                 i_packet_available,
  input  logic                 i_fifo_empty,
  input  logic                 i_fifo_rd_valid,
  input  rx_buffer_pkg::word_t i_fifo_rd_data,
  output logic                 o_fifo_rd_start,
  output logic                 o_packet_read,
  rx_ram_if.loader             mem
);
  import access_port_pkg::*;

  loader_state_e         state_q;
  logic [ADDR_WIDTH-1:0] word_cnt_q;
  logic                  packet_read_q;
  logic                  start;
  logic                  last;

  // ----------------------------------------------------------
  // Start and end of a packet
  // ----------------------------------------------------------

  // The parser must be idle so that it is not reading the old packet
  assign start = (state_q == LD_IDLE) && i_packet_available && !i_fifo_empty &&
                 !i_parser_busy;

  // FIFO drained and no word in flight
  assign last = (state_q == LD_LOADING) && !i_fifo_rd_valid && i_fifo_empty;

  assign o_fifo_rd_start = start;
  assign o_packet_read   = packet_read_q;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q       <= LD_IDLE;
      word_cnt_q    <= '0;
      packet_read_q <= 1'b0;
    end else begin
      packet_read_q <= last;
      case (state_q)
        LD_IDLE: begin
          if (start) begin
            state_q    <= LD_LOADING;
            word_cnt_q <= '0;
          end
        end
        LD_LOADING: begin
          if (i_fifo_rd_valid) begin
            word_cnt_q <= word_cnt_q + 1'b1;
          end else if (i_fifo_empty) begin
            state_q <= LD_IDLE;
          end
        end
        default: begin
          state_q <= LD_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // RAM write port
  // ----------------------------------------------------------

  // Each valid FIFO word lands at the next word address
  assign mem.wr_en   = (state_q == LD_LOADING) && i_fifo_rd_valid;
  assign mem.wr_addr = word_cnt_q;
  assign mem.wr_data = i_fifo_rd_data;

  // A FIFO word that arrives outside a load would never reach the RAM
  a_word_while_loading: assert property (@(posedge i_clk) disable iff (i_areset)
    i_fifo_rd_valid |-> (state_q == LD_LOADING));

endmodule

// File: flist.f
rx_buffer_pkg.sv
access_port_pkg.sv
rx_ram_if.sv
dispatch_loader.sv
rx_packet_ram.sv
access_port_reader.sv
nts_rx_buffer.sv
rx_buffer_checker.sv
tb_nts_rx_buffer.sv

// File: nts_rx_buffer.sv
`timescale 1ns/1ps

module nts_rx_buffer #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                                               i_clk,
  input  logic                                               i_areset,

  input  logic                                               i_parser_busy,

  // Dispatch FIFO side
  input  logic                                               i_dispatch_packet_available,
  output logic                                               o_dispatch_packet_read,
  input  logic                                               i_dispatch_fifo_empty,
  output logic                                               o_dispatch_fifo_rd_start,
  input  logic                                               i_dispatch_fifo_rd_valid,
  input  rx_buffer_pkg::word_t                               i_dispatch_fifo_rd_data,

  // Parser access port
  output logic                                               o_access_port_wait,
  input  logic [ADDR_WIDTH+rx_buffer_pkg::BYTE_LANE_BITS-1:0] i_access_port_addr,
  input  logic [2:0]                                         i_access_port_wordsize,
  input  logic                                               i_access_port_rd_en,
  output logic                                               o_access_port_rd_dv,
  output rx_buffer_pkg::word_t                               o_access_port_rd_data
);

  // ----------------------------------------------------------
  // Packet RAM ports
  // ----------------------------------------------------------

  rx_ram_if #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_ram_if ();

  dispatch_loader #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_dispatch_loader (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_parser_busy      (i_parser_busy),
    .i_packet_available (i_dispatch_packet_available),
    .i_fifo_empty       (i_dispatch_fifo_empty),
    .i_fifo_rd_valid    (i_dispatch_fifo_rd_valid),
    .i_fifo_rd_data     (i_dispatch_fifo_rd_data),
    .o_fifo_rd_start    (o_dispatch_fifo_rd_start),
    .o_packet_read      (o_dispatch_packet_read),
    .mem                (u_ram_if.loader)
  );

  rx_packet_ram #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_rx_packet_ram (
    .i_clk (i_clk),
    .mem   (u_ram_if.ram)
  );

  // Parser keeps reads and loads apart through i_parser_busy
  access_port_reader #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_access_port_reader (
    .i_clk      (i_clk),
    .i_areset   (i_areset),
    .i_rd_en    (i_access_port_rd_en),
    .i_addr     (i_access_port_addr),
    .i_wordsize (i_access_port_wordsize),
    .o_wait     (o_access_port_wait),
    .o_rd_dv    (o_access_port_rd_dv),
    .o_rd_data  (o_access_port_rd_data),
    .mem        (u_ram_if.reader)
  );

endmodule

// File: rx_buffer_checker.sv
`timescale 1ns/1ps

module rx_buffer_checker #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                                               i_clk,
  input  logic                                               i_areset,
  input  logic                                               i_parser_busy,
  input  logic                                               i_packet_available,
  input  logic                                               i_packet_read,
  input  logic                                               i_fifo_empty,
  input  logic                                               i_fifo_rd_start,
  input  logic                                               i_fifo_rd_valid,
  input  rx_buffer_pkg::word_t                               i_fifo_rd_data,
  input  logic                                               i_wait,
  input  logic [ADDR_WIDTH+rx_buffer_pkg::BYTE_LANE_BITS-1:0] i_addr,
  input  logic [2:0]                                         i_wordsize,
  input  logic                                               i_rd_en,
  input  logic                                               i_rd_dv,
  input  rx_buffer_pkg::word_t                               i_rd_data,
  output int                                                 o_mismatches,
  output int                                                 o_reads,
  output int                                                 o_packets,
  output int                                                 o_starts
);
  import rx_buffer_pkg::*;
  import access_port_pkg::*;

  // Shadow of the packet RAM, filled from the FIFO words at the ports
  word_t      shadow [2**ADDR_WIDTH];
  logic       loading;
  logic       exp_start;
  logic       exp_read;
  int         wr_idx;
  logic       pending;
  int         waited;
  int         latency;
  int         nbytes;
  word_size_e size;
  word_t      exp_data;
  int         mismatches = 0;
  int         reads = 0;
  int         packets = 0;
  int         starts = 0;

  assign o_mismatches = mismatches;
  assign o_reads      = reads;
  assign o_packets    = packets;
  assign o_starts     = starts;

  task automatic check_value(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s = %0h, expected %0h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  // Big-endian bytes from addr onward, first byte ends up most significant
  function automatic word_t expected_read(int addr, int count);
    word_t result;
    word_t w;
    int    a;
    result = '0;
    for (int i = 0; i < count; i++) begin
      a = addr + i;
      w = shadow[a / BYTES_PER_WORD];
      result = (result << 8) | word_t'(w[WORD_WIDTH-1-8*(a % BYTES_PER_WORD) -: 8]);
    end
    return result;
  endfunction

  always @(posedge i_clk) begin
    if (i_areset) begin
      loading  = 1'b0;
      exp_read = 1'b0;
      pending  = 1'b0;
      wr_idx   = 0;
    end else begin
      // ----------------------------------------------------------
      // Loader model
      // ----------------------------------------------------------
      exp_start = !loading && i_packet_available && !i_fifo_empty && !i_parser_busy;
      check_value("o_dispatch_fifo_rd_start", i_fifo_rd_start, exp_start);
      check_value("o_dispatch_packet_read", i_packet_read, exp_read);
      if (i_fifo_rd_start) starts++;
      if (i_packet_read) packets++;
      exp_read = loading && !i_fifo_rd_valid && i_fifo_empty;
      if (exp_start) begin
        loading = 1'b1;
        wr_idx  = 0;
      end else if (loading && i_fifo_rd_valid) begin
        shadow[wr_idx] = i_fifo_rd_data;
        wr_idx++;
      end else if (exp_read) begin
        loading = 1'b0;
      end

      // ----------------------------------------------------------
      // Access port model
      // ----------------------------------------------------------
      if (pending) begin
        waited++;
        check_value("o_access_port_wait", i_wait, waited <= latency);
        check_value("o_access_port_rd_dv", i_rd_dv, waited > latency);
        if (waited > latency) begin
          check_value("o_access_port_rd_data", i_rd_data, exp_data);
          reads++;
          pending = 1'b0;
        end
      end else begin
        check_value("o_access_port_wait", i_wait, 1'b0);
        check_value("o_access_port_rd_dv", i_rd_dv, 1'b0);
      end
      // Sizes 4 to 7 and requests during a read are not taken
      if (!pending && i_rd_en && !i_wordsize[2]) begin
        size     = word_size_e'(i_wordsize[1:0]);
        nbytes   = 1 << int'(size);
        exp_data = expected_read(int'(i_addr), nbytes);
        latency  = ((int'(i_addr) % BYTES_PER_WORD) + nbytes > BYTES_PER_WORD) ? 4 : 3;
        waited   = 0;
        pending  = 1'b1;
      end
    end
  end

endmodule

// File: rx_buffer_pkg.sv
package rx_buffer_pkg;

  // ----------------------------------------------------------
  // Receive buffer geometry
  // ----------------------------------------------------------

  // Width of one RAM word and of the dispatch FIFO data
  localparam int WORD_WIDTH = 64;

  // Bytes held in one word
  localparam int BYTES_PER_WORD = WORD_WIDTH / 8;

  // Low byte address bits that select a byte lane inside a word
  localparam int BYTE_LANE_BITS = $clog2(BYTES_PER_WORD);

  // One packet RAM word
  typedef logic [WORD_WIDTH-1:0] word_t;

endpackage

// File: rx_packet_ram.sv
`timescale 1ns/1ps

module rx_packet_ram #(
  parameter int ADDR_WIDTH = 8
) (
  input logic   i_clk,
  rx_ram_if.ram mem
);
  import rx_buffer_pkg::*;

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  // Packet storage, maps onto block RAM
  word_t ram_q [DEPTH];
  word_t rd_data_q;

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (mem.wr_en) begin
      ram_q[mem.wr_addr] <= mem.wr_data;
    end
  end

  // ----------------------------------------------------------
  // Registered read port
  // ----------------------------------------------------------

  // Same address as a write in this cycle gives the old word
  always_ff @(posedge i_clk) begin
    rd_data_q <= ram_q[mem.rd_addr];
  end

  assign mem.rd_data = rd_data_q;

endmodule

// File: rx_ram_if.sv
`timescale 1ns/1ps

interface rx_ram_if #(
  parameter int ADDR_WIDTH = 8
);
  import rx_buffer_pkg::*;

  // Write port driven by the loader
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  word_t                 wr_data;

  // Read port with the data one cycle after the address
  logic [ADDR_WIDTH-1:0] rd_addr;
  word_t                 rd_data;

  modport loader (
    output wr_en,
    output wr_addr,
    output wr_data
  );

  modport reader (
    output rd_addr,
    input  rd_data
  );

  modport ram (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface

// File: tb_nts_rx_buffer.sv
`timescale 1ns/1ps

module tb_nts_rx_buffer;
  import rx_buffer_pkg::*;

  localparam int ADDR_WIDTH       = 8;
  localparam int CLK_PERIOD       = 8;
  localparam int NUM_PACKETS      = 3;
  localparam int READS_PER_PACKET = 200;
  localparam int MAX_CYCLES = (NUM_PACKETS * 40 + NUM_PACKETS * READS_PER_PACKET * 10) * 2;

  logic                                clk;
  logic                                areset;
  logic                                parser_busy;
  logic                                packet_available;
  logic                                packet_read;
  logic                                fifo_empty;
  logic                                fifo_rd_start;
  logic                                fifo_rd_valid;
  word_t                               fifo_rd_data;
  logic                                ap_wait;
  logic [ADDR_WIDTH+BYTE_LANE_BITS-1:0] ap_addr;
  logic [2:0]                          ap_wordsize;
  logic                                ap_rd_en;
  logic                                ap_rd_dv;
  word_t                               ap_rd_data;

  integer seed;
  int     packet_words;
  int     cycle_count;
  int     other_errors;
  int     mismatches;
  int     reads_checked;
  int     packets_seen;
  int     starts_seen;

  always #(CLK_PERIOD / 2) clk = ~clk;

  nts_rx_buffer #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_nts_rx_buffer (
    .i_clk                       (clk),
    .i_areset                    (areset),
    .i_parser_busy               (parser_busy),
    .i_dispatch_packet_available (packet_available),
    .o_dispatch_packet_read      (packet_read),
    .i_dispatch_fifo_empty       (fifo_empty),
    .o_dispatch_fifo_rd_start    (fifo_rd_start),
    .i_dispatch_fifo_rd_valid    (fifo_rd_valid),
    .i_dispatch_fifo_rd_data     (fifo_rd_data),
    .o_access_port_wait          (ap_wait),
    .i_access_port_addr          (ap_addr),
    .i_access_port_wordsize      (ap_wordsize),
    .i_access_port_rd_en         (ap_rd_en),
    .o_access_port_rd_dv         (ap_rd_dv),
    .o_access_port_rd_data       (ap_rd_data)
  );

  rx_buffer_checker #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_checker (
    .i_clk              (clk),
    .i_areset           (areset),
    .i_parser_busy      (parser_busy),
    .i_packet_available (packet_available),
    .i_packet_read      (packet_read),
    .i_fifo_empty       (fifo_empty),
    .i_fifo_rd_start    (fifo_rd_start),
    .i_fifo_rd_valid    (fifo_rd_valid),
    .i_fifo_rd_data     (fifo_rd_data),
    .i_wait             (ap_wait),
    .i_addr             (ap_addr),
    .i_wordsize         (ap_wordsize),
    .i_rd_en            (ap_rd_en),
    .i_rd_dv            (ap_rd_dv),
    .i_rd_data          (ap_rd_data),
    .o_mismatches       (mismatches),
    .o_reads            (reads_checked),
    .o_packets          (packets_seen),
    .o_starts           (starts_seen)
  );

  function automatic int random_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic report_counts();
    $display("Error counts: %0d mismatches, %0d other errors", mismatches, other_errors);
  endtask

  // ----------------------------------------------------------
  // Dispatch FIFO model
  // ----------------------------------------------------------

  // Packet is announced while the parser is still busy, so no start yet
  task automatic load_packet();
    logic [31:0] hi;
    logic [31:0] lo;
    packet_words     = 4 + random_below(29);
    parser_busy      = 1'b1;
    packet_available = 1'b1;
    fifo_empty       = 1'b0;
    repeat (random_below(4)) @(negedge clk);
    parser_busy = 1'b0;
    @(posedge clk);
    while (!fifo_rd_start) @(posedge clk);
    @(negedge clk);
    packet_available = 1'b0;
    for (int n = 0; n < packet_words; n++) begin
      fifo_rd_valid = 1'b0;
      repeat (random_below(3)) @(negedge clk);
      hi = $random(seed);
      lo = $random(seed);
      fifo_rd_valid = 1'b1;
      fifo_rd_data  = {hi, lo};
      @(negedge clk);
    end
    fifo_rd_valid = 1'b0;
    fifo_empty    = 1'b1;
    @(negedge clk);
    while (!packet_read) @(negedge clk);
  endtask

  // ----------------------------------------------------------
  // Access port requests
  // ----------------------------------------------------------

  task automatic drive_read(int size_code, int byte_addr);
    ap_rd_en    = 1'b1;
    ap_wordsize = size_code[2:0];
    ap_addr     = byte_addr[ADDR_WIDTH+BYTE_LANE_BITS-1:0];
    @(negedge clk);
    ap_rd_en = 1'b0;
  endtask

  task automatic run_reads();
    int code;
    int nbytes;
    int addr;
    parser_busy = 1'b1;
    for (int r = 0; r < READS_PER_PACKET; r++) begin
      // Undefined size codes
      if (random_below(8) == 0) begin
        drive_read(4 + random_below(4), random_below(packet_words * BYTES_PER_WORD));
      end
      code   = random_below(4);
      nbytes = 1 << code;
      addr   = random_below(packet_words * BYTES_PER_WORD - nbytes + 1);
      if (r % 4 == 0) begin
        addr = addr - (addr % nbytes);
      end
      drive_read(code, addr);
      // Extra request while wait is high
      if (random_below(4) == 0) begin
        drive_read(random_below(8), random_below(packet_words * BYTES_PER_WORD));
      end
      while (!ap_rd_dv) @(negedge clk);
    end
  endtask

  initial begin
    seed             = 32'hda08;
    other_errors     = 0;
    clk              = 1'b0;
    areset           = 1'b1;
    parser_busy      = 1'b1;
    packet_available = 1'b0;
    fifo_empty       = 1'b1;
    fifo_rd_valid    = 1'b0;
    fifo_rd_data     = '0;
    ap_addr          = '0;
    ap_wordsize      = '0;
    ap_rd_en         = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    areset = 1'b0;
    repeat (2) @(negedge clk);
    repeat (NUM_PACKETS) begin
      load_packet();
      run_reads();
    end
    repeat (4) @(negedge clk);
    if (starts_seen != NUM_PACKETS || packets_seen != NUM_PACKETS) begin
      $display("Error: %0d FIFO read starts and %0d packet read pulses for %0d packets",
               starts_seen, packets_seen, NUM_PACKETS);
      other_errors++;
    end
    if (reads_checked != NUM_PACKETS * READS_PER_PACKET) begin
      $display("Error: %0d read results seen, %0d reads issued", reads_checked,
               NUM_PACKETS * READS_PER_PACKET);
      other_errors++;
    end
    report_counts();
    if (mismatches == 0 && other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    @(negedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
    other_errors++;
    report_counts();
    $display("tests failed");
    $finish;
  end

endmodule
